// ==== hdl/eth_pkg.sv ====
package eth_pkg;

	typedef logic [7:0]  byte_t;				// one byte of frame data
	typedef logic [3:0]  nibble_t;				// one rgmii data nibble
	typedef logic [31:0] crc_t;					// crc-32 register value
	typedef logic [10:0] fifo_addr_t;			// pointer into the transmit buffer
	typedef logic [11:0] frame_count_t;			// complete frames held in the transmit buffer

	typedef enum logic [1:0] {
		speed_10m   = 2'd0,
		speed_100m  = 2'd1,
		speed_1000m = 2'd2
	} lspeed_t;									// encoding matches bits 2:1 of the in-band status nibble

	typedef enum logic [1:0] {
		rx_st_idle,								// waiting for the first preamble byte
		rx_st_preamble,							// counting preamble bytes until the sfd
		rx_st_data,								// frame body including the fcs
		rx_st_drop								// bad framing so ignore the rest of the frame
	} rx_state_t;

	typedef enum logic [2:0] {
		tx_st_idle,
		tx_st_preamble,
		tx_st_sfd,
		tx_st_data,
		tx_st_fcs,
		tx_st_gap
	} tx_state_t;

	localparam int    TX_FIFO_DEPTH = 2048;		// bytes of transmit buffer
	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE      = 8'hd5;
	localparam int    PREAMBLE_LEN  = 7;		// preamble bytes before the sfd
	localparam int    IFG_LEN       = 12;		// interframe gap in byte times
	localparam crc_t  CRC_POLY      = 32'hedb88320;	// reflected ieee 802.3 polynomial
	localparam crc_t  CRC_INIT      = 32'hffffffff;
	localparam crc_t  CRC_RESIDUE   = 32'hdebb20e3;	// register value after a good frame plus its fcs

endpackage

// ==== hdl/rgmii_nibble_bridge.sv ====
module rgmii_nibble_bridge import eth_pkg::*; (
	input wire			clk_125mhz,
	input wire			reset,

	input nibble_t		rgmii_rxd,
	input wire			rgmii_rx_ctl,
	output nibble_t		rgmii_txd,
	output logic		rgmii_tx_ctl,

	input wire			gmii_tx_valid,
	input byte_t		gmii_tx_data,
	input wire			gmii_tx_en,

	output logic		gmii_rx_valid,
	output byte_t		gmii_rx_data,
	output logic		gmii_rx_dv,

	output logic		link_up,
	output lspeed_t		link_speed
);

	logic		rx_phase;							// high once the low nibble of a byte has been taken
	nibble_t	rx_low;								// low nibble waiting for its partner
	nibble_t	tx_high;							// high nibble queued behind the low one

	// receive control, nibble pairing and in-band status
	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			rx_phase		<= 1'b0;
			gmii_rx_valid	<= 1'b0;
			gmii_rx_dv		<= 1'b0;
			link_up			<= 1'b0;
			link_speed		<= speed_10m;
		end else begin
			gmii_rx_valid	<= 1'b0;				// strobe lasts a single cycle
			gmii_rx_dv		<= rgmii_rx_ctl;		// falls one cycle after the last nibble
			if (rgmii_rx_ctl) begin
				rx_phase		<= !rx_phase;
				gmii_rx_valid	<= rx_phase;		// second nibble completes the byte
			end else begin
				// between frames the phy reports link state on rxd
				rx_phase	<= 1'b0;					// every frame starts on a low nibble
				link_up		<= rgmii_rxd[0];
				link_speed	<= lspeed_t'(rgmii_rxd[2:1]);
			end
		end
	end

	// receive data path
	always_ff @(posedge clk_125mhz) begin
		if (rgmii_rx_ctl && !rx_phase)
			rx_low <= rgmii_rxd;					// low nibble arrives first
		if (rgmii_rx_ctl && rx_phase)
			gmii_rx_data <= {rgmii_rxd, rx_low};
	end

	// transmit side sends the low nibble and then the high nibble
	always_ff @(posedge clk_125mhz) begin
		if (gmii_tx_valid) begin
			rgmii_txd	<= gmii_tx_data[3:0];		// low nibble one cycle after the strobe
			tx_high		<= gmii_tx_data[7:4];
		end else begin
			rgmii_txd	<= tx_high;				// high nibble in the following cycle
			tx_high		<= '0;					// idle pins settle to zero
		end
	end

	always_ff @(posedge clk_125mhz) begin
		if (reset)
			rgmii_tx_ctl <= 1'b0;
		else
			rgmii_tx_ctl <= gmii_tx_en;			// lines up with the nibble registered above
	end

endmodule

// ==== hdl/eth_crc32.sv ====
module eth_crc32 import eth_pkg::*; (
	input wire		clk_125mhz,
	input wire		reset,
	input wire		crc_init,
	input wire		crc_update,
	input byte_t	crc_data,
	output crc_t	crc
);

	// fold one byte into the register, lsb first, using the reflected polynomial
	function automatic crc_t crc_byte(input crc_t crc_in, input byte_t data);
		crc_t c;
		c = crc_in;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ data[i])
				c = (c >> 1) ^ CRC_POLY;			// feedback bit set so apply the polynomial
			else
				c = c >> 1;
		end
		return c;
	endfunction

	always_ff @(posedge clk_125mhz) begin
		if (reset)
			crc <= CRC_INIT;
		else if (crc_init)
			crc <= CRC_INIT;						// init wins over a byte in the same cycle
		else if (crc_update)
			crc <= crc_byte(crc, crc_data);
	end

endmodule

// ==== hdl/eth_rx_mac.sv ====
module eth_rx_mac import eth_pkg::*; (
	input wire			clk_125mhz,
	input wire			reset,

	input wire			gmii_rx_valid,
	input byte_t		gmii_rx_data,
	input wire			gmii_rx_dv,

	output logic		rx_valid,
	output byte_t		rx_data,
	output logic		rx_last,
	output logic		rx_crc_ok
);

	rx_state_t	state;
	logic [2:0]	pre_count;							// preamble bytes seen so far
	logic [2:0]	line_fill;							// bytes held in the delay line
	byte_t		dline [5];							// holds back the fcs until the frame ends
	logic		frame_end;							// dv fell while in the frame body
	logic		line_full;
	logic		sfd_hit;
	logic		data_strobe;
	crc_t		crc;

	assign line_full	= (line_fill == 3'd5);
	assign data_strobe	= (state == rx_st_data) && gmii_rx_valid && gmii_rx_dv;
	assign sfd_hit		= (state == rx_st_preamble) && gmii_rx_valid && gmii_rx_dv &&
		(gmii_rx_data == SFD_BYTE) && (pre_count == PREAMBLE_LEN);

	eth_crc32 crc_calc(
		.clk_125mhz(clk_125mhz),
		.reset(reset),
		.crc_init(sfd_hit),							// restart on the sfd
		.crc_update(data_strobe),					// payload and fcs both go through
		.crc_data(gmii_rx_data),
		.crc(crc)
	);

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			state		<= rx_st_idle;
			pre_count	<= '0;
			line_fill	<= '0;
			frame_end	<= 1'b0;
			rx_valid	<= 1'b0;
			rx_last		<= 1'b0;
			rx_crc_ok	<= 1'b0;
		end else begin
			rx_valid	<= data_strobe && line_full;	// oldest byte leaves as a new one enters
			rx_last		<= 1'b0;
			rx_crc_ok	<= 1'b0;
			frame_end	<= 1'b0;

			// the last byte in the line is the final payload byte
			if (frame_end) begin
				rx_valid	<= line_full;				// runt frames produce nothing
				rx_last		<= line_full;
				rx_crc_ok	<= line_full && (crc == CRC_RESIDUE);
			end

			if (sfd_hit)
				line_fill <= '0;
			else if (data_strobe && !line_full)
				line_fill <= line_fill + 3'd1;

			if (!gmii_rx_dv) begin
				frame_end	<= (state == rx_st_data);
				state		<= rx_st_idle;
			end else if (gmii_rx_valid) begin
				case (state)
					rx_st_idle: begin
						pre_count	<= 3'd1;
						state		<= (gmii_rx_data == PREAMBLE_BYTE) ? rx_st_preamble : rx_st_drop;
					end
					rx_st_preamble: begin
						if (sfd_hit)
							state <= rx_st_data;
						else if (gmii_rx_data == PREAMBLE_BYTE && pre_count < PREAMBLE_LEN)
							pre_count <= pre_count + 3'd1;
						else
							state <= rx_st_drop;			// wrong byte or too much preamble
					end
					default: state <= state;			// data and drop run until dv falls
				endcase
			end
		end
	end

	always_ff @(posedge clk_125mhz) begin
		if (data_strobe) begin
			dline[0] <= gmii_rx_data;
			for (int i = 1; i < 5; i++)
				dline[i] <= dline[i - 1];
		end
		if (data_strobe || frame_end)
			rx_data <= dline[4];
	end

endmodule

// ==== hdl/eth_tx_fifo.sv ====
module eth_tx_fifo import eth_pkg::*; (
	input wire			clk_125mhz,
	input wire			reset,

	input wire			tx_valid,
	input byte_t		tx_data,
	input wire			tx_last,
	output logic		tx_full,

	input wire			fifo_pop,
	output logic		frame_ready,
	output byte_t		fifo_data,
	output logic		fifo_last
);

	logic [8:0]		mem [TX_FIFO_DEPTH];			// end of frame flag above the data byte
	fifo_addr_t		wr_ptr;
	fifo_addr_t		rd_ptr;
	fifo_addr_t		used;							// pointers wrap naturally at the depth
	frame_count_t	frame_count;
	logic			wr_en;
	logic			rd_en;

	assign used			= wr_ptr - rd_ptr;
	assign tx_full		= (used > fifo_addr_t'(TX_FIFO_DEPTH - 2));	// fewer than two slots free
	assign wr_en		= tx_valid && !tx_full;
	assign rd_en		= fifo_pop && (used != '0);
	assign frame_ready	= (frame_count != '0);

	assign {fifo_last, fifo_data} = mem[rd_ptr];		// head entry is visible before the pop

	always_ff @(posedge clk_125mhz) begin
		if (wr_en)
			mem[wr_ptr] <= {tx_last, tx_data};
	end

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			wr_ptr		<= '0;
			rd_ptr		<= '0;
			frame_count	<= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en && tx_last, rd_en && fifo_last})
				2'b10:		frame_count <= frame_count + 1'b1;	// a frame finished arriving
				2'b01:		frame_count <= frame_count - 1'b1;	// its last byte left
				default:	frame_count <= frame_count;
			endcase
		end
	end

endmodule

// ==== hdl/eth_tx_mac.sv ====
module eth_tx_mac import eth_pkg::*; (
	input wire			clk_125mhz,
	input wire			reset,

	input wire			frame_ready,
	input byte_t		fifo_data,
	input wire			fifo_last,
	output logic		fifo_pop,

	input wire			link_up,

	output logic		gmii_tx_valid,
	output byte_t		gmii_tx_data,
	output logic		gmii_tx_en
);

	tx_state_t	state;
	logic [4:0]	cnt;								// preamble, fcs and gap position
	logic		beat;								// second cycle of a byte slot
	logic		start;
	logic		active;
	logic		byte_strobe;
	byte_t		tx_byte;
	crc_t		crc;
	crc_t		fcs_word;
	byte_t		fcs_byte;

	assign start		= (state == tx_st_idle) && frame_ready && link_up;
	assign active		= (state == tx_st_preamble) || (state == tx_st_sfd) ||
		(state == tx_st_data) || (state == tx_st_fcs);
	assign byte_strobe	= active && !beat;			// one byte every two cycles
	assign fifo_pop		= byte_strobe && (state == tx_st_data);
	assign fcs_word		= ~crc;						// fcs is the inverted register
	assign fcs_byte		= fcs_word[8 * cnt[1:0] +: 8];	// low byte goes out first

	eth_crc32 crc_calc(
		.clk_125mhz(clk_125mhz),
		.reset(reset),
		.crc_init(start),
		.crc_update(fifo_pop),						// only payload bytes count
		.crc_data(fifo_data),
		.crc(crc)
	);

	always_comb begin
		case (state)
			tx_st_preamble:	tx_byte = PREAMBLE_BYTE;
			tx_st_sfd:		tx_byte = SFD_BYTE;
			tx_st_data:		tx_byte = fifo_data;
			tx_st_fcs:		tx_byte = fcs_byte;
			default:		tx_byte = '0;
		endcase
	end

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			state			<= tx_st_idle;
			cnt				<= '0;
			beat			<= 1'b0;
			gmii_tx_valid	<= 1'b0;
			gmii_tx_en		<= 1'b0;
		end else begin
			gmii_tx_valid	<= byte_strobe;
			gmii_tx_en		<= byte_strobe || gmii_tx_valid;	// covers both nibbles of each byte
			beat			<= byte_strobe;
			case (state)
				tx_st_idle: begin
					cnt <= '0;
					if (start)
						state <= tx_st_preamble;
				end
				tx_st_preamble: begin
					if (byte_strobe && cnt == PREAMBLE_LEN - 1) begin
						state	<= tx_st_sfd;
						cnt		<= '0;
					end else if (byte_strobe)
						cnt <= cnt + 5'd1;
				end
				tx_st_sfd: begin
					if (byte_strobe)
						state <= tx_st_data;
				end
				tx_st_data: begin
					if (byte_strobe && fifo_last)
						state <= tx_st_fcs;				// the frame in the fifo is complete
				end
				tx_st_fcs: begin
					if (byte_strobe && cnt == 5'd3) begin
						state	<= tx_st_gap;
						cnt		<= '0;
					end else if (byte_strobe)
						cnt <= cnt + 5'd1;
				end
				tx_st_gap: begin
					// the gap is counted in cycles, two per byte time
					if (cnt == 2 * IFG_LEN - 1)
						state <= tx_st_idle;
					cnt <= cnt + 5'd1;
				end
				default: state <= tx_st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_125mhz) begin
		if (byte_strobe)
			gmii_tx_data <= tx_byte;
	end

endmodule

// ==== hdl/rgmii_mac_wrapper.sv ====
module rgmii_mac_wrapper import eth_pkg::*; (
	input wire			clk_125mhz,
	input wire			reset,

	// rgmii pins to the phy
	input nibble_t		rgmii_rxd,
	input wire			rgmii_rx_ctl,
	output nibble_t		rgmii_txd,
	output wire			rgmii_tx_ctl,

	// received frames to the host
	output wire			rx_valid,
	output byte_t		rx_data,
	output wire			rx_last,
	output wire			rx_crc_ok,

	// frames from the host
	input wire			tx_valid,
	input byte_t		tx_data,
	input wire			tx_last,
	output wire			tx_full,

	output wire			link_up,
	output lspeed_t		link_speed
);

	wire	gmii_rx_valid;
	byte_t	gmii_rx_data;
	wire	gmii_rx_dv;
	wire	gmii_tx_valid;
	byte_t	gmii_tx_data;
	wire	gmii_tx_en;
	wire	frame_ready;
	wire	fifo_pop;
	byte_t	fifo_data;
	wire	fifo_last;

	rgmii_nibble_bridge bridge(
		.clk_125mhz(clk_125mhz),
		.reset(reset),
		.rgmii_rxd(rgmii_rxd),
		.rgmii_rx_ctl(rgmii_rx_ctl),
		.rgmii_txd(rgmii_txd),
		.rgmii_tx_ctl(rgmii_tx_ctl),
		.gmii_tx_valid(gmii_tx_valid),
		.gmii_tx_data(gmii_tx_data),
		.gmii_tx_en(gmii_tx_en),
		.gmii_rx_valid(gmii_rx_valid),
		.gmii_rx_data(gmii_rx_data),
		.gmii_rx_dv(gmii_rx_dv),
		.link_up(link_up),
		.link_speed(link_speed)
	);

	eth_rx_mac rx_mac(
		.clk_125mhz(clk_125mhz),
		.reset(reset),
		.gmii_rx_valid(gmii_rx_valid),
		.gmii_rx_data(gmii_rx_data),
		.gmii_rx_dv(gmii_rx_dv),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_last(rx_last),
		.rx_crc_ok(rx_crc_ok)
	);

	eth_tx_fifo tx_fifo(
		.clk_125mhz(clk_125mhz),
		.reset(reset),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_last(tx_last),
		.tx_full(tx_full),
		.fifo_pop(fifo_pop),
		.frame_ready(frame_ready),
		.fifo_data(fifo_data),
		.fifo_last(fifo_last)
	);

	eth_tx_mac tx_mac(
		.clk_125mhz(clk_125mhz),
		.reset(reset),
		.frame_ready(frame_ready),
		.fifo_data(fifo_data),
		.fifo_last(fifo_last),
		.fifo_pop(fifo_pop),
		.link_up(link_up),						// frames wait in the fifo while the link is down
		.gmii_tx_valid(gmii_tx_valid),
		.gmii_tx_data(gmii_tx_data),
		.gmii_tx_en(gmii_tx_en)
	);

endmodule

// ==== sim/rgmii_mac_tb.sv ====
module rgmii_mac_tb import eth_pkg::*; ();

	logic		clk_125mhz;
	logic		reset;
	nibble_t	rgmii_rxd;
	logic		rgmii_rx_ctl;
	nibble_t	rgmii_txd;
	logic		rgmii_tx_ctl;
	logic		rx_valid;
	byte_t		rx_data;
	logic		rx_last;
	logic		rx_crc_ok;
	logic		tx_valid;
	byte_t		tx_data;
	logic		tx_last;
	logic		tx_full;
	logic		link_up;
	lspeed_t	link_speed;

	int			fd;									// trace file handle
	int			value_errors = 0;
	int			other_errors = 0;
	int			watchdog_cycles = 0;				// stays zero until the trace is sized
	nibble_t	cur_status = '0;					// nibble the phy shows between frames
	bit			link_expected = 0;
	crc_t		crc_table [256];					// byte-wise lookup for the reference fcs
	byte_t		rx_bytes [$];						// payload seen by the receive monitor
	bit			rx_lasts [$];
	bit			rx_done;
	bit			rx_crc_seen;
	byte_t		exp_payload [$];					// transmit payloads still owed on the pins
	int			exp_lens [$];
	crc_t		exp_fcs [$];
	byte_t		pin_bytes [$];						// bytes rebuilt from rgmii_txd
	nibble_t	low_nib;
	bit			in_frame = 0;
	int			nib_count;
	int			gap_cycles = 0;
	int			frames_seen = 0;

	rgmii_mac_wrapper DUT(.*);

	initial begin
		clk_125mhz = 1'b0;
		forever #10 clk_125mhz = ~clk_125mhz;
	end

	initial begin : build_crc_table
		crc_t c;
		for (int i = 0; i < 256; i++) begin
			c = i;
			repeat (8)
				c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);	// reflected polynomial, lsb first
			crc_table[i] = c;
		end
	end

	task automatic report_problem(input string msg);
		$display("%s", msg);
		other_errors++;
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input bit exp, input logic act);
		if (act !== exp) begin
			$display("error %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_speed(input string name, input lspeed_t exp, input lspeed_t act);
		if (act !== exp) begin
			$display("error %s: expected %0d, actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_crc(input string name, input crc_t exp, input crc_t act);
		if (act !== exp) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	// every host and pin output has a defined level once reset has been applied
	task automatic check_reset_values();
		check_flag("reset rx_valid", 1'b0, rx_valid);
		check_flag("reset rx_last", 1'b0, rx_last);
		check_flag("reset rx_crc_ok", 1'b0, rx_crc_ok);
		check_flag("reset rgmii_tx_ctl", 1'b0, rgmii_tx_ctl);
		check_flag("reset link_up", 1'b0, link_up);
		check_flag("reset tx_full", 1'b0, tx_full);
		check_speed("reset link_speed", speed_10m, link_speed);
	endtask

	// receive monitor, outputs only move on the rising edge
	always @(negedge clk_125mhz) begin
		if (!reset && rx_valid === 1'b1) begin
			rx_bytes.push_back(rx_data);
			rx_lasts.push_back(rx_last);
			if (rx_last === 1'b1) begin
				rx_done = 1;
				rx_crc_seen = rx_crc_ok;				// verdict travels with the last byte
			end
		end
	end

	// compare one finished pin frame with the oldest pending transmit frame
	task automatic check_tx_frame();
		int n;
		crc_t fcs;
		string name;
		name = $sformatf("tx frame %0d", frames_seen);
		if (exp_lens.size() == 0) begin
			report_problem($sformatf("%s appeared on the pins with no frame pending", name));
		end else begin
			n = exp_lens.pop_front();
			fcs = exp_fcs.pop_front();
			if (nib_count % 2 != 0 || pin_bytes.size() != n + 12) begin
				report_problem($sformatf("%s carried %0d nibbles instead of %0d", name, nib_count,
					2 * (n + 12)));
				repeat (n)
					exp_payload.delete(0);				// keep later frames aligned
			end else begin
				for (int i = 0; i < 7; i++)
					check_byte($sformatf("%s preamble %0d", name, i), PREAMBLE_BYTE, pin_bytes[i]);
				check_byte({name, " sfd"}, SFD_BYTE, pin_bytes[7]);
				for (int i = 0; i < n; i++)
					check_byte($sformatf("%s byte %0d", name, i), exp_payload.pop_front(),
						pin_bytes[8 + i]);
				check_crc({name, " fcs"}, fcs, {pin_bytes[n + 11], pin_bytes[n + 10],
					pin_bytes[n + 9], pin_bytes[n + 8]});	// fcs goes out low byte first
			end
		end
	endtask

	// pin monitor pairs nibbles into bytes and times the gaps
	always @(negedge clk_125mhz) begin
		if (reset) begin
			in_frame = 0;
		end else if (rgmii_tx_ctl === 1'b1) begin
			if (!in_frame) begin
				if (!link_expected)
					report_problem("transmit activity on the pins while the link is down");
				if (frames_seen > 0 && gap_cycles < 2 * IFG_LEN)
					report_problem($sformatf("interframe gap of only %0d cycles", gap_cycles));
				in_frame = 1;
				nib_count = 0;
				pin_bytes.delete();
			end
			if (nib_count % 2 == 0)
				low_nib = rgmii_txd;					// low nibble comes first
			else
				pin_bytes.push_back({rgmii_txd, low_nib});
			nib_count++;
		end else if (in_frame) begin
			in_frame = 0;
			gap_cycles = 1;								// this sample is the first idle one
			frames_seen++;
			check_tx_frame();
		end else begin
			gap_cycles++;
		end
	end

	task automatic apply_link_status(input int idx);
		logic [31:0] status;
		int exp_up;
		int exp_speed;
		int got;
		got = $fscanf(fd, "%h %d %d", status, exp_up, exp_speed);
		if (got != 3)
			report_problem($sformatf("link line %0d in the trace is malformed", idx));
		cur_status = status[3:0];
		@(negedge clk_125mhz);
		rgmii_rxd = cur_status;						// rx_ctl is low so this is status
		link_expected = exp_up[0];
		repeat (2) @(negedge clk_125mhz);
		check_flag($sformatf("link %0d link_up", idx), exp_up[0], link_up);
		check_speed($sformatf("link %0d link_speed", idx), lspeed_t'(exp_speed), link_speed);
	endtask

	task automatic send_rx_frame(input int idx);
		int pre_ok;
		int exp_ok;
		int n;
		int got;
		int waited;
		logic [31:0] val;
		byte_t b;
		byte_t wire_bytes [$];
		string name;
		got = $fscanf(fd, "%d %d %d", pre_ok, exp_ok, n);
		name = $sformatf("rx %0d", idx);
		if (got != 3)
			report_problem($sformatf("%s line in the trace is malformed", name));
		for (int i = 0; i < PREAMBLE_LEN; i++)
			wire_bytes.push_back((pre_ok == 0 && i == 2) ? 8'h5a : PREAMBLE_BYTE);	// break byte 2
		wire_bytes.push_back(SFD_BYTE);
		for (int i = 0; i < n; i++) begin
			got = $fscanf(fd, "%h", val);
			if (got != 1)
				report_problem($sformatf("%s is missing frame byte %0d", name, i));
			wire_bytes.push_back(val[7:0]);
		end
		rx_bytes.delete();
		rx_lasts.delete();
		rx_done = 0;
		foreach (wire_bytes[i]) begin
			b = wire_bytes[i];
			@(negedge clk_125mhz);
			rgmii_rx_ctl = 1'b1;
			rgmii_rxd = b[3:0];
			@(negedge clk_125mhz);
			rgmii_rxd = b[7:4];
		end
		@(negedge clk_125mhz);
		rgmii_rx_ctl = 1'b0;
		rgmii_rxd = cur_status;						// back to status between frames
		waited = 0;
		while (!rx_done && waited < 20) begin
			@(negedge clk_125mhz);
			waited++;
		end
		if (pre_ok == 0) begin
			if (rx_bytes.size() != 0)
				report_problem($sformatf("%s has a broken preamble but gave %0d bytes", name,
					rx_bytes.size()));
		end else if (!rx_done || rx_bytes.size() != n - 4) begin
			report_problem($sformatf("%s gave %0d payload bytes instead of %0d", name,
				rx_bytes.size(), n - 4));
		end else begin
			for (int i = 0; i < n - 4; i++) begin
				check_byte($sformatf("%s byte %0d", name, i), wire_bytes[8 + i], rx_bytes[i]);
				check_flag($sformatf("%s rx_last %0d", name, i), i == n - 5, rx_lasts[i]);
			end
			check_flag({name, " rx_crc_ok"}, exp_ok[0], rx_crc_seen);
		end
	endtask

	task automatic write_tx_frame(input int idx);
		logic [31:0] val;
		int n;
		int got;
		int stall;
		crc_t c;
		got = $fscanf(fd, "%d", n);
		if (got != 1)
			report_problem($sformatf("tx line %0d in the trace is malformed", idx));
		c = CRC_INIT;
		for (int i = 0; i < n; i++) begin
			got = $fscanf(fd, "%h", val);
			if (got != 1)
				report_problem($sformatf("tx %0d is missing payload byte %0d", idx, i));
			exp_payload.push_back(val[7:0]);
			c = (c >> 8) ^ crc_table[c[7:0] ^ val[7:0]];	// table form of the reflected crc
			@(negedge clk_125mhz);
			// the few short frames in flight stay far below the buffer depth
			check_flag($sformatf("tx %0d byte %0d tx_full", idx, i), 1'b0, tx_full);
			stall = 0;
			while (tx_full === 1'b1 && stall < 1000) begin
				tx_valid = 1'b0;
				@(negedge clk_125mhz);
				stall++;
			end
			if (stall == 1000)
				report_problem($sformatf("tx %0d: tx_full stayed high for 1000 cycles", idx));
			tx_valid = 1'b1;
			tx_data = val[7:0];
			tx_last = (i == n - 1);
		end
		@(negedge clk_125mhz);
		tx_valid = 1'b0;
		tx_last = 1'b0;
		exp_lens.push_back(n);						// frame_ready only rises after this point
		exp_fcs.push_back(~c);
	endtask

	task automatic drain_tx();
		int waited;
		waited = 0;
		while ((exp_lens.size() != 0 || in_frame) && waited < 3000) begin
			@(negedge clk_125mhz);
			waited++;
		end
		if (waited == 3000)
			report_problem("transmit frames were still pending after 3000 cycles");
	endtask

	initial begin : watchdog
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk_125mhz);
		$display("timeout: the trace did not finish within %0d cycles", watchdog_cycles);
		$display("value errors %0d, other errors %0d", value_errors, other_errors + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : run_trace
		logic [127:0] word;
		logic [8*256-1:0] rest;
		int items;
		int step;
		int got;
		int cycles;
		items = 0;
		step = 0;
		reset = 1'b1;
		rgmii_rxd = '0;
		rgmii_rx_ctl = 1'b0;
		tx_valid = 1'b0;
		tx_data = '0;
		tx_last = 1'b0;
		fd = $fopen("sim/rgmii_mac_trace.txt", "r");
		if (fd == 0) begin
			report_problem("could not open sim/rgmii_mac_trace.txt");
		end else begin
			// every value after a keyword counts as one trace byte
			while ($fscanf(fd, "%s", word) == 1) begin
				if (word == "#")
					got = $fgets(rest, fd);
				else if (word != "link" && word != "rx" && word != "tx" && word != "wait" &&
					word != "drain")
					items++;
			end
			$fclose(fd);
			fd = $fopen("sim/rgmii_mac_trace.txt", "r");
		end
		watchdog_cycles = 40 * items + 2000;
		repeat (4) @(posedge clk_125mhz);
		@(negedge clk_125mhz);
		check_reset_values();
		reset = 1'b0;
		if (fd != 0) begin
			while ($fscanf(fd, "%s", word) == 1) begin
				step++;
				if (word == "#") begin
					got = $fgets(rest, fd);
				end else if (word == "link") begin
					apply_link_status(step);
				end else if (word == "rx") begin
					send_rx_frame(step);
				end else if (word == "tx") begin
					write_tx_frame(step);
				end else if (word == "wait") begin
					got = $fscanf(fd, "%d", cycles);
					repeat (cycles) @(negedge clk_125mhz);
				end else if (word == "drain") begin
					drain_tx();
				end else begin
					report_problem($sformatf("unknown keyword in trace entry %0d", step));
					got = $fgets(rest, fd);
				end
			end
			$fclose(fd);
		end
		drain_tx();
		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== eth_rgmii.f ====
hdl/eth_pkg.sv
hdl/rgmii_nibble_bridge.sv
hdl/eth_crc32.sv
hdl/eth_rx_mac.sv
hdl/eth_tx_fifo.sv
hdl/eth_tx_mac.sv
hdl/rgmii_mac_wrapper.sv
sim/rgmii_mac_tb.sv

// ==== sim/rgmii_mac_trace.txt ====
# link <status nibble> <expected link_up> <expected speed 0=10m 1=100m 2=1000m>
# rx <preamble intact> <expected crc_ok> <count> <payload bytes then fcs, low fcs byte first>
# tx <count> <payload bytes>, wait <cycles>, drain waits until every transmit frame is out
link 0 0 0
link 5 1 2
link 3 1 1
rx 1 1 13 31 32 33 34 35 36 37 38 39 26 39 f4 cb
rx 1 1 7 61 62 63 c2 41 24 35
rx 1 0 7 61 62 63 c2 41 24 36
rx 1 1 5 61 43 be b7 e8
rx 0 0 13 31 32 33 34 35 36 37 38 39 26 39 f4 cb
tx 6 00 11 22 33 44 55
tx 3 de ad be
tx 12 01 02 03 04 05 06 07 08 09 0a 0b 0c
drain
# the link drops and a frame written now has to wait for it
link 0 0 0
tx 5 a5 5a c3 3c ff
wait 150
link 1 1 0
drain
rx 1 1 7 61 62 63 c2 41 24 35
